// File: source/missunit_defines.svh
//////////////////////////////
// the last miss port carries stores only
// MU_INDEX_W counts the offset bits as well as the set bits
//////////////////////////////
`ifndef MISSUNIT_DEFINES_SVH
`define MISSUNIT_DEFINES_SVH

// miss ports, the highest one is the store port
`define MU_NUM_PORTS 3
// physical address and store data
`define MU_PADDR_W   32
`define MU_WDATA_W   32
// cache geometry, 4 ways of 16 sets with 16 byte lines
`define MU_WAYS      4
`define MU_OFFSET_W  4
`define MU_INDEX_W   8
`define MU_LINE_W    128
// transaction ids and store credits
`define MU_ID_W      2
`define MU_MAX_TX    4

`endif

// File: source/missunit_pkg.sv
//////////////////////////////
// types shared by the miss handler blocks
// all widths follow the defines header
//////////////////////////////
`include "missunit_defines.svh"

package missunit_pkg;

  // request kind towards memory
  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_rtype_e;

  // return kind from memory
  typedef enum logic {
    RTRN_LOAD_ACK  = 1'b0,
    RTRN_STORE_ACK = 1'b1
  } rtrn_type_e;

  typedef logic [$clog2(`MU_WAYS)-1:0]             way_idx_t;
  typedef logic [1:0]                              port_idx_t;
  typedef logic [`MU_INDEX_W-`MU_OFFSET_W-1:0]     set_idx_t;

  // one outgoing memory request
  typedef struct packed {
    mem_rtype_e              rtype;
    logic [`MU_ID_W-1:0]     tid;
    logic [`MU_PADDR_W-1:0]  paddr;
    logic [`MU_WDATA_W-1:0]  wdata;
    way_idx_t                way;
  } mem_req_t;

  // the single outstanding read
  typedef struct packed {
    logic [`MU_PADDR_W-1:0]  paddr;
    logic [`MU_ID_W-1:0]     id;
    way_idx_t                repl_way;
    port_idx_t               port_idx;
  } mshr_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    DRAIN,
    FLUSH,
    STORE_WAIT,
    LOAD_WAIT
  } ctrl_state_e;

endpackage

// File: source/miss_port_arbiter.sv
//////////////////////////////
// fixed priority, lowest port wins
// ports hold req and fields until acked
//////////////////////////////
`timescale 1ns/1ps
`include "missunit_defines.svh"

module miss_port_arbiter import missunit_pkg::*; #(
  parameter int unsigned NumPorts = `MU_NUM_PORTS
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [NumPorts-1:0] miss_req_i,
  input  logic [NumPorts-1:0] miss_we_i,
  input  logic                mask_reads_i,
  input  logic                lock_reqs_i,
  output logic                req_any_o,
  output port_idx_t           port_idx_o,
  output logic                is_write_o
);

  logic [NumPorts-1:0] req_masked_d, req_masked_q;

  // lock replays last cycle's mask while a request waits for its ack
  // otherwise reads may be hidden so only the store port competes
  assign req_masked_d = lock_reqs_i  ? req_masked_q           :
                        mask_reads_i ? (miss_req_i & miss_we_i) :
                                       miss_req_i;

  assign req_any_o  = |req_masked_d;
  assign is_write_o = miss_we_i[port_idx_o];

  // scan downwards so the lowest set bit is the last one kept
  always_comb begin
    port_idx_o = '0;
    for (int k = NumPorts - 1; k >= 0; k--) begin
      if (req_masked_d[k]) begin
        port_idx_o = port_idx_t'(k);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_masked_q <= '0;
    end else begin
      req_masked_q <= req_masked_d;
    end
  end

  //////////////////////////////
  // assertions
  //////////////////////////////

  // stores only on the last port, and that port never reads
  a_store_port : assert property (@(posedge clk_i) disable iff (!rst_ni)
    |miss_req_i |-> ((miss_req_i & miss_we_i) == (miss_req_i & (1 << (NumPorts - 1)))))
    else $error("miss port we does not match the port role");

endmodule

// File: source/refill_way_select.sv
//////////////////////////////
// refill way from the lowest invalid way
// LFSR way once the set is full
//////////////////////////////
`timescale 1ns/1ps
`include "missunit_defines.svh"

module refill_way_select import missunit_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [`MU_WAYS-1:0] vld_bits_i,
  input  logic               step_i,
  output way_idx_t           repl_way_o,
  output logic               all_valid_o
);

  logic [7:0] lfsr_q;
  logic [7:0] lfsr_d;
  way_idx_t   inv_way;
  way_idx_t   rnd_way;

  assign all_valid_o = &vld_bits_i;

  // lowest zero in the valid bits
  always_comb begin
    inv_way = '0;
    for (int k = `MU_WAYS - 1; k >= 0; k--) begin
      if (!vld_bits_i[k]) begin
        inv_way = way_idx_t'(k);
      end
    end
  end

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_d  = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
  // ways are a power of two so the low bits give the modulo
  assign rnd_way = lfsr_q[$clog2(`MU_WAYS)-1:0];

  assign repl_way_o = all_valid_o ? rnd_way : inv_way;

  // only steps when a random victim was consumed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'hff;
    end else if (step_i) begin
      lfsr_q <= lfsr_d;
    end
  end

endmodule

// File: source/miss_ctrl_fsm.sv
//////////////////////////////
// one read outstanding in a single MSHR
// enabling goes through a flush, disabling is immediate
//////////////////////////////
`timescale 1ns/1ps
`include "missunit_defines.svh"

module miss_ctrl_fsm import missunit_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   enable_i,
  input  logic                   flush_i,
  input  logic                   wbuffer_empty_i,
  input  logic                   req_any_i,
  input  logic                   is_write_i,
  input  port_idx_t              port_idx_i,
  input  logic [`MU_PADDR_W-1:0] miss_paddr_i,
  input  logic [`MU_ID_W-1:0]    miss_id_i,
  input  way_idx_t               repl_way_i,
  input  logic                   all_valid_i,
  input  logic                   mem_ack_i,
  input  logic                   load_ack_i,
  input  logic                   stores_pending_i,
  output logic                   mask_reads_o,
  output logic                   lock_reqs_o,
  output logic                   mem_req_o,
  output mem_rtype_e             mem_rtype_o,
  output logic                   alloc_o,
  output logic                   lfsr_step_o,
  output mshr_t                  mshr_o,
  output logic                   mshr_vld_o,
  output logic                   flush_en_o,
  output set_idx_t               flush_idx_o,
  output logic                   flush_ack_o,
  output logic                   cache_en_o,
  output logic                   miss_o
);

  ctrl_state_e state_d, state_q;
  mshr_t       mshr_d, mshr_q;
  logic        mshr_vld_d, mshr_vld_q;
  logic        enable_d, enable_q;
  logic        flush_ack_d, flush_ack_q;
  set_idx_t    cnt_d, cnt_q;
  logic        flush_done;
  logic        st_collide;
  logic        drained;

  //////////////////////////////
  // MSHR and sweep counter
  //////////////////////////////

  // store to the line being refilled waits for the return
  assign st_collide = mshr_vld_q &&
    (mshr_q.paddr[`MU_PADDR_W-1:`MU_OFFSET_W] == miss_paddr_i[`MU_PADDR_W-1:`MU_OFFSET_W]);
  // no read out, no store queued or in flight
  assign drained    = wbuffer_empty_i && !mshr_vld_q && !stores_pending_i;

  assign mshr_d     = alloc_o ? '{paddr: miss_paddr_i, id: miss_id_i,
                                  repl_way: repl_way_i, port_idx: port_idx_i} : mshr_q;
  // a new read may be accepted in the cycle the old one returns
  assign mshr_vld_d = alloc_o ? 1'b1 : (load_ack_i ? 1'b0 : mshr_vld_q);

  // one set per cycle, counter wraps back to zero after the last set
  assign cnt_d       = flush_en_o ? cnt_q + 1'b1 : '0;
  assign flush_done  = (cnt_q == '1);
  assign flush_idx_o = cnt_q;

  assign mshr_o     = mshr_q;
  assign mshr_vld_o = mshr_vld_q;
  assign cache_en_o = enable_q;
  // every read is cacheable, so each allocation is a miss
  assign miss_o     = alloc_o;

  //////////////////////////////
  // controller
  //////////////////////////////

  always_comb begin
    state_d      = state_q;
    enable_d     = enable_q & enable_i;
    flush_ack_d  = flush_ack_q;
    flush_ack_o  = 1'b0;
    flush_en_o   = 1'b0;
    mask_reads_o = mshr_vld_q & ~load_ack_i;
    lock_reqs_o  = 1'b0;
    mem_req_o    = 1'b0;
    mem_rtype_o  = MEM_LOAD;
    alloc_o      = 1'b0;
    lfsr_step_o  = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (flush_i || (enable_i && !enable_q)) begin
          // only an explicit flush is acknowledged
          flush_ack_d = flush_i;
          state_d     = drained ? FLUSH : DRAIN;
        end else if (req_any_i && is_write_i) begin
          if (!st_collide) begin
            mem_req_o   = 1'b1;
            mem_rtype_o = MEM_STORE;
            if (!mem_ack_i) begin
              state_d = STORE_WAIT;
            end
          end
        end else if (req_any_i) begin
          // reads reach here only with a free or freeing MSHR
          mem_req_o   = 1'b1;
          alloc_o     = mem_ack_i;
          lfsr_step_o = all_valid_i & mem_ack_i;
          if (!mem_ack_i) begin
            state_d = LOAD_WAIT;
          end
        end
      end
      STORE_WAIT: begin
        lock_reqs_o = 1'b1;
        mem_req_o   = 1'b1;
        mem_rtype_o = MEM_STORE;
        if (mem_ack_i) begin
          state_d = IDLE;
        end
      end
      LOAD_WAIT: begin
        lock_reqs_o = 1'b1;
        mem_req_o   = 1'b1;
        if (mem_ack_i) begin
          alloc_o     = 1'b1;
          lfsr_step_o = all_valid_i;
          state_d     = IDLE;
        end
      end
      DRAIN: begin
        // stores keep flowing, reads wait for the sweep
        mask_reads_o = 1'b1;
        flush_ack_d  = flush_ack_q | flush_i;
        if (req_any_i && !st_collide) begin
          mem_req_o   = 1'b1;
          mem_rtype_o = MEM_STORE;
        end
        if (drained) begin
          state_d = FLUSH;
        end
      end
      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done) begin
          flush_ack_o = flush_ack_q;
          flush_ack_d = 1'b0;
          enable_d    = enable_i;
          state_d     = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // reset starts with a sweep of every set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      mshr_vld_q  <= 1'b0;
      enable_q    <= 1'b0;
      flush_ack_q <= 1'b0;
      cnt_q       <= '0;
    end else begin
      state_q     <= state_d;
      mshr_vld_q  <= mshr_vld_d;
      enable_q    <= enable_d;
      flush_ack_q <= flush_ack_d;
      cnt_q       <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    mshr_q <= mshr_d;
  end

endmodule

// File: source/miss_rtrn_decode.sv
//////////////////////////////
// returns have no back-pressure
// stray acks are dropped
//////////////////////////////
`timescale 1ns/1ps
`include "missunit_defines.svh"

module miss_rtrn_decode import missunit_pkg::*; #(
  parameter int unsigned NumPorts = `MU_NUM_PORTS
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  mem_rtrn_vld_i,
  input  rtrn_type_e                            mem_rtrn_type_i,
  input  logic [`MU_ID_W-1:0]                   mem_rtrn_tid_i,
  input  logic [`MU_LINE_W-1:0]                 mem_rtrn_data_i,
  input  logic                                  store_sent_i,
  input  mshr_t                                 mshr_i,
  input  logic                                  mshr_vld_i,
  input  logic                                  flush_en_i,
  input  set_idx_t                              flush_idx_i,
  output logic                                  load_ack_o,
  output logic                                  stores_pending_o,
  output logic [NumPorts-1:0]                   miss_rtrn_vld_o,
  output logic [`MU_ID_W-1:0]                   miss_rtrn_id_o,
  output logic                                  wr_cl_vld_o,
  output logic [`MU_WAYS-1:0]                   wr_cl_we_o,
  output logic [`MU_PADDR_W-`MU_INDEX_W-1:0]    wr_cl_tag_o,
  output set_idx_t                              wr_cl_idx_o,
  output logic [`MU_LINE_W-1:0]                 wr_cl_data_o,
  output logic [`MU_WAYS-1:0]                   wr_vld_bits_o
);

  localparam int unsigned CntW = $clog2(`MU_MAX_TX + 1);

  logic [CntW-1:0]     stores_d, stores_q;
  logic                store_ack;
  logic [`MU_WAYS-1:0] way_oh;

  // ack kinds only count while something is waiting for them
  assign load_ack_o = mem_rtrn_vld_i && (mem_rtrn_type_i == RTRN_LOAD_ACK) && mshr_vld_i;
  assign store_ack  = mem_rtrn_vld_i && (mem_rtrn_type_i == RTRN_STORE_ACK) && stores_pending_o;

  // stores in flight
  assign stores_pending_o = |stores_q;
  assign stores_d = (store_ack && store_sent_i) ? stores_q          :
                    store_ack                   ? stores_q - 1'b1   :
                    store_sent_i                ? stores_q + 1'b1   :
                                                  stores_q;

  // loads go back to the port held in the MSHR, stores to the last port
  always_comb begin
    miss_rtrn_vld_o = '0;
    if (load_ack_o) begin
      miss_rtrn_vld_o[mshr_i.port_idx] = 1'b1;
    end
    if (store_ack) begin
      miss_rtrn_vld_o[NumPorts-1] = 1'b1;
    end
  end

  // the write buffer matches store acks by id
  assign miss_rtrn_id_o = mem_rtrn_tid_i;

  //////////////////////////////
  // cache line write port
  //////////////////////////////

  assign way_oh = {{(`MU_WAYS-1){1'b0}}, 1'b1} << mshr_i.repl_way;

  // sweep hits all ways of one set and clears their valid bits
  assign wr_cl_vld_o   = flush_en_i | load_ack_o;
  assign wr_cl_we_o    = flush_en_i ? '1 : (load_ack_o ? way_oh : '0);
  assign wr_vld_bits_o = flush_en_i ? '0 : (load_ack_o ? way_oh : '0);
  assign wr_cl_idx_o   = flush_en_i ? flush_idx_i
                                    : mshr_i.paddr[`MU_INDEX_W-1:`MU_OFFSET_W];
  assign wr_cl_tag_o   = mshr_i.paddr[`MU_PADDR_W-1:`MU_INDEX_W];
  assign wr_cl_data_o  = mem_rtrn_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stores_q <= '0;
    end else begin
      stores_q <= stores_d;
    end
  end

  //////////////////////////////
  // assertions
  //////////////////////////////

  // write buffer must not send more stores than there are credits
  a_store_cnt : assert property (@(posedge clk_i) disable iff (!rst_ni)
    stores_q <= CntW'(`MU_MAX_TX))
    else $error("stores in flight exceed MU_MAX_TX");

  // a refill belongs to the read the controller allocated
  a_load_tid : assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_ack_o |-> (mem_rtrn_tid_i == mshr_i.id))
    else $error("load return tid does not match the MSHR id");

endmodule

// File: source/dcache_missunit.sv
//////////////////////////////
// miss handler of a write-through L1 data cache
// NumPorts >= 2, last port stores only
//////////////////////////////
`timescale 1ns/1ps
`include "missunit_defines.svh"

module dcache_missunit import missunit_pkg::*; #(
  parameter int unsigned NumPorts = `MU_NUM_PORTS
) (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // cache management
  input  logic                                      enable_i,
  input  logic                                      flush_i,
  output logic                                      flush_ack_o,
  output logic                                      miss_o,
  input  logic                                      wbuffer_empty_i,
  output logic                                      cache_en_o,
  // miss ports
  input  logic [NumPorts-1:0]                       miss_req_i,
  output logic [NumPorts-1:0]                       miss_ack_o,
  input  logic [NumPorts-1:0]                       miss_we_i,
  input  logic [NumPorts-1:0][`MU_WDATA_W-1:0]      miss_wdata_i,
  input  logic [NumPorts-1:0][`MU_PADDR_W-1:0]      miss_paddr_i,
  input  logic [NumPorts-1:0][`MU_WAYS-1:0]         miss_vld_bits_i,
  input  logic [NumPorts-1:0][`MU_ID_W-1:0]         miss_id_i,
  output logic [NumPorts-1:0]                       miss_rtrn_vld_o,
  output logic [`MU_ID_W-1:0]                       miss_rtrn_id_o,
  // cache line write port
  output logic                                      wr_cl_vld_o,
  output logic [`MU_WAYS-1:0]                       wr_cl_we_o,
  output logic [`MU_PADDR_W-`MU_INDEX_W-1:0]        wr_cl_tag_o,
  output set_idx_t                                  wr_cl_idx_o,
  output logic [`MU_LINE_W-1:0]                     wr_cl_data_o,
  output logic [`MU_WAYS-1:0]                       wr_vld_bits_o,
  // memory
  input  logic                                      mem_rtrn_vld_i,
  input  rtrn_type_e                                mem_rtrn_type_i,
  input  logic [`MU_ID_W-1:0]                       mem_rtrn_tid_i,
  input  logic [`MU_LINE_W-1:0]                     mem_rtrn_data_i,
  output logic                                      mem_req_o,
  input  logic                                      mem_ack_i,
  output mem_req_t                                  mem_data_o
);

  logic       req_any, is_write, mask_reads, lock_reqs;
  logic       lfsr_step, all_valid;
  logic       load_ack, stores_pending, store_sent;
  logic       mshr_vld, flush_en;
  port_idx_t  port_idx;
  way_idx_t   repl_way;
  mshr_t      mshr;
  set_idx_t   flush_idx;
  mem_rtype_e rtype;

  // winner's fields go straight to memory
  assign mem_data_o = '{rtype: rtype, tid: miss_id_i[port_idx], paddr: miss_paddr_i[port_idx],
                        wdata: miss_wdata_i[port_idx], way: repl_way};
  assign store_sent = mem_req_o & mem_ack_i & (rtype == MEM_STORE);

  // port ack is the memory accept
  always_comb begin
    miss_ack_o           = '0;
    miss_ack_o[port_idx] = mem_req_o & mem_ack_i;
  end

  miss_port_arbiter #(.NumPorts(NumPorts)) i_arb (
    .clk_i, .rst_ni, .miss_req_i, .miss_we_i,
    .mask_reads_i (mask_reads), .lock_reqs_i (lock_reqs),
    .req_any_o    (req_any),    .port_idx_o  (port_idx), .is_write_o (is_write)
  );

  refill_way_select i_way (
    .clk_i, .rst_ni,
    .vld_bits_i (miss_vld_bits_i[port_idx]), .step_i      (lfsr_step),
    .repl_way_o (repl_way),                  .all_valid_o (all_valid)
  );

  miss_ctrl_fsm i_ctrl (
    .clk_i, .rst_ni, .enable_i, .flush_i, .wbuffer_empty_i,
    .req_any_i    (req_any),                .is_write_i       (is_write),
    .port_idx_i   (port_idx),               .miss_paddr_i     (miss_paddr_i[port_idx]),
    .miss_id_i    (miss_id_i[port_idx]),    .repl_way_i       (repl_way),
    .all_valid_i  (all_valid),              .mem_ack_i,
    .load_ack_i   (load_ack),               .stores_pending_i (stores_pending),
    .mask_reads_o (mask_reads),             .lock_reqs_o      (lock_reqs),
    .mem_req_o,   .mem_rtype_o (rtype),     .alloc_o          (),
    .lfsr_step_o  (lfsr_step),              .mshr_o           (mshr),
    .mshr_vld_o   (mshr_vld),               .flush_en_o       (flush_en),
    .flush_idx_o  (flush_idx),              .flush_ack_o, .cache_en_o, .miss_o
  );

  miss_rtrn_decode #(.NumPorts(NumPorts)) i_rtrn (
    .clk_i, .rst_ni, .mem_rtrn_vld_i, .mem_rtrn_type_i, .mem_rtrn_tid_i, .mem_rtrn_data_i,
    .store_sent_i (store_sent), .mshr_i (mshr), .mshr_vld_i (mshr_vld),
    .flush_en_i   (flush_en),   .flush_idx_i (flush_idx),
    .load_ack_o   (load_ack),   .stores_pending_o (stores_pending),
    .miss_rtrn_vld_o, .miss_rtrn_id_o, .wr_cl_vld_o, .wr_cl_we_o,
    .wr_cl_tag_o, .wr_cl_idx_o, .wr_cl_data_o, .wr_vld_bits_o
  );

endmodule

// File: tests/tb_dcache_missunit.sv
//////////////////////////////
// random miss traffic against a memory model with random delays
//////////////////////////////
`timescale 1ns/1ps
`include "missunit_defines.svh"

module tb_dcache_missunit import missunit_pkg::*;;

  localparam int N = `MU_NUM_PORTS;
  localparam int NumBatches = 26;
  // worst batch is three requests, each with ack and return delay, plus three sweeps
  localparam int WatchdogCycles = 16 + 3 * 40 + NumBatches * 48;

  logic clk_i, rst_ni, enable_i, flush_i, flush_ack_o, miss_o, wbuffer_empty_i, cache_en_o;
  logic [N-1:0] miss_req_i, miss_ack_o, miss_we_i, miss_rtrn_vld_o;
  logic [N-1:0][`MU_WDATA_W-1:0] miss_wdata_i;
  logic [N-1:0][`MU_PADDR_W-1:0] miss_paddr_i;
  logic [N-1:0][`MU_WAYS-1:0] miss_vld_bits_i;
  logic [N-1:0][`MU_ID_W-1:0] miss_id_i;
  logic [`MU_ID_W-1:0] miss_rtrn_id_o, mem_rtrn_tid_i;
  logic wr_cl_vld_o, mem_rtrn_vld_i, mem_req_o, mem_ack_i;
  logic [`MU_WAYS-1:0] wr_cl_we_o, wr_vld_bits_o;
  logic [`MU_PADDR_W-`MU_INDEX_W-1:0] wr_cl_tag_o;
  set_idx_t wr_cl_idx_o;
  logic [`MU_LINE_W-1:0] wr_cl_data_o, mem_rtrn_data_i;
  rtrn_type_e mem_rtrn_type_i;
  mem_req_t mem_data_o;

  logic [31:0] lfsr = 32'hd090;
  int err_cnt = 0;
  // traffic in flight as seen by the memory model
  int reads_out = 0;
  int stores_out = 0;
  logic [31:0] rd_addr;
  logic [`MU_ID_W-1:0] rd_tid;
  int rd_port, rd_way;

  dcache_missunit dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  // memory contents, every line differs with its address
  function automatic logic [127:0] line_of(input logic [31:0] a);
    logic [31:0] la;
    la = {a[31:4], 4'h0};
    return {~la, la ^ 32'h1357_9bdf, {la[15:0], la[31:16]}, la + 32'h0f0f_0f0f};
  endfunction

  // lowest invalid way, -1 when the set is full
  function automatic int lowest_invalid_way(input logic [`MU_WAYS-1:0] vld);
    for (int k = 0; k < `MU_WAYS; k++) begin
      if (!vld[k]) return k;
    end
    return -1;
  endfunction

  // lowest read port wins while the MSHR is free, else only the store port
  function automatic int expected_port(input logic [N-1:0] req, input logic slot_free);
    if (slot_free) begin
      for (int k = 0; k < N - 1; k++) begin
        if (req[k]) return k;
      end
    end
    return N - 1;
  endfunction

  task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERROR: t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "compare mismatch");
    end
  endtask

  //////////////////////////////
  // memory model and compare
  //////////////////////////////

  initial begin : mem_model
    logic q_load[$];
    logic [1:0] q_tid[$];
    logic [31:0] q_addr[$];
    int q_dly[$];
    logic [31:0] r;
    logic ack_nxt, rtn_nxt, rtn_load, nxt_load, waiting;
    logic [1:0] nxt_tid;
    logic [31:0] nxt_addr;
    int ack_wait, p;
    waiting = 1'b0;
    ack_wait = 0;
    p = 0;
    forever begin
      @(negedge clk_i);
      ack_nxt = 1'b0;
      rtn_nxt = 1'b0;
      if (rst_ni) begin
        rtn_load = mem_rtrn_type_i == RTRN_LOAD_ACK;
        if (mem_rtrn_vld_i && rtn_load) begin
          check("miss_rtrn_vld_o", miss_rtrn_vld_o, 1 << rd_port);
          check("miss_rtrn_id_o", miss_rtrn_id_o, rd_tid);
          check("wr_cl_vld_o", wr_cl_vld_o, 1);
          check("wr_cl_tag_o", wr_cl_tag_o, rd_addr[31:8]);
          check("wr_cl_idx_o", wr_cl_idx_o, rd_addr[7:4]);
          check("wr_cl_data_o", wr_cl_data_o, line_of(rd_addr));
          if (rd_way >= 0) begin
            check("wr_cl_we_o", wr_cl_we_o, 1 << rd_way);
            check("wr_vld_bits_o", wr_vld_bits_o, 1 << rd_way);
          end else begin
            check("wr_cl_we_o onehot", $onehot(wr_cl_we_o), 1);
            check("wr_vld_bits_o onehot", $onehot(wr_vld_bits_o), 1);
          end
          reads_out--;
        end else if (mem_rtrn_vld_i) begin
          check("miss_rtrn_vld_o", miss_rtrn_vld_o, 1 << (N - 1));
          check("miss_rtrn_id_o", miss_rtrn_id_o, mem_rtrn_tid_i);
          stores_out--;
        end
        // a sweep only runs with everything drained
        if (wr_cl_vld_o && wr_cl_we_o == '1) begin
          check("sweep drained", {wbuffer_empty_i, reads_out == 0, stores_out == 0}, 3'b111);
        end
        if (mem_req_o) begin
          if (!waiting) p = expected_port(miss_req_i, reads_out == 0);
          if (p == N - 1 && reads_out != 0) begin
            check("store hits MSHR line", miss_paddr_i[p][31:4] == rd_addr[31:4], 0);
          end
          check("miss_ack_o", miss_ack_o, mem_ack_i ? (1 << p) : 0);
          check("mem_data_o.paddr", mem_data_o.paddr, miss_paddr_i[p]);
          check("mem_data_o.tid", mem_data_o.tid, miss_id_i[p]);
          check("mem_data_o.rtype", mem_data_o.rtype, p == N - 1);
          if (mem_ack_i) begin
            waiting = 1'b0;
            rand_bits(2, r);
            ack_wait = r;
            if (p != N - 1) begin
              check("second read before return", reads_out, 0);
              reads_out++;
              rd_addr = miss_paddr_i[p];
              rd_tid = miss_id_i[p];
              rd_port = p;
              rd_way = lowest_invalid_way(miss_vld_bits_i[p]);
              if (rd_way >= 0) check("mem_data_o.way", mem_data_o.way, rd_way);
            end else begin
              check("mem_data_o.wdata", mem_data_o.wdata, miss_wdata_i[p]);
              stores_out++;
            end
            rand_bits(3, r);
            q_load.push_back(p != N - 1);
            q_tid.push_back(miss_id_i[p]);
            q_addr.push_back(miss_paddr_i[p]);
            q_dly.push_back(r + 1);
          end else begin
            waiting = 1'b1;
            if (ack_wait > 0) ack_wait--;
            else ack_nxt = 1'b1;
          end
        end
        // every accepted read is a miss
        check("miss_o", miss_o, mem_req_o && mem_ack_i && p != N - 1);
        // returns come back in order, one per cycle at most
        if (q_dly.size() > 0) begin
          if (q_dly[0] > 0) begin
            q_dly[0]--;
          end else begin
            rtn_nxt = 1'b1;
            nxt_load = q_load.pop_front();
            nxt_tid = q_tid.pop_front();
            nxt_addr = q_addr.pop_front();
            void'(q_dly.pop_front());
          end
        end
      end
      @(posedge clk_i);
      mem_ack_i <= ack_nxt;
      mem_rtrn_vld_i <= rtn_nxt;
      if (rtn_nxt) begin
        mem_rtrn_type_i <= nxt_load ? RTRN_LOAD_ACK : RTRN_STORE_ACK;
        mem_rtrn_tid_i <= nxt_tid;
        mem_rtrn_data_i <= nxt_load ? line_of(nxt_addr) : '0;
      end
    end
  end

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////

  // raise the masked ports together and hold each until its ack
  task automatic run_batch(input logic [N-1:0] mask, input logic collide, input logic full);
    logic [31:0] r, a0;
    logic [N-1:0] pend;
    pend = mask;
    a0 = '0;
    @(posedge clk_i);
    for (int p = 0; p < N; p++) begin
      if (mask[p]) begin
        rand_bits(32, r);
        if (p < N - 1) a0 = r;
        miss_paddr_i[p] <= (p == N - 1 && collide) ? (a0 ^ 32'h4) : r;
        rand_bits(32, r);
        miss_wdata_i[p] <= r;
        rand_bits(4, r);
        miss_vld_bits_i[p] <= (p == 0 && full) ? 4'hf : r[3:0];
        rand_bits(2, r);
        miss_id_i[p] <= r[1:0];
        miss_req_i[p] <= 1'b1;
      end
    end
    while (pend != '0) begin
      @(negedge clk_i);
      pend = pend & ~miss_ack_o;
      @(posedge clk_i);
      miss_req_i <= miss_req_i & pend;
    end
  endtask

  task automatic wait_quiet();
    while (reads_out != 0 || stores_out != 0) @(posedge clk_i);
  endtask

  // finds the first sweep cycle, then follows all 16 sets
  task automatic check_sweep(input logic expect_ack);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!(wr_cl_vld_o && wr_cl_we_o == '1) && n < 60) begin
      n++;
      @(negedge clk_i);
    end
    check("sweep started", n < 60, 1);
    for (int k = 0; k < 16; k++) begin
      check("wr_cl_vld_o", wr_cl_vld_o, 1);
      check("wr_cl_we_o", wr_cl_we_o, 4'hf);
      check("wr_vld_bits_o", wr_vld_bits_o, 0);
      check("wr_cl_idx_o", wr_cl_idx_o, k);
      check("flush_ack_o", flush_ack_o, expect_ack && k == 15);
      if (k == 0) begin
        @(posedge clk_i);
        flush_i <= 1'b0;
      end
      @(negedge clk_i);
    end
    check("wr_cl_vld_o after sweep", wr_cl_vld_o, 0);
    check("flush_ack_o after sweep", flush_ack_o, 0);
  endtask

  initial begin : watchdog
    #(WatchdogCycles * 40);
    $display("watchdog expired, the DUT stopped answering");
    $display("sim failed");
    $fatal(1, "timeout");
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin : main
    logic [31:0] r;
    rst_ni = 1'b0;
    enable_i = 1'b0;
    flush_i = 1'b0;
    wbuffer_empty_i = 1'b1;
    miss_req_i = '0;
    miss_we_i = 1 << (N - 1);
    miss_wdata_i = '0;
    miss_paddr_i = '0;
    miss_vld_bits_i = '0;
    miss_id_i = '0;
    mem_rtrn_vld_i = 1'b0;
    mem_rtrn_type_i = RTRN_LOAD_ACK;
    mem_rtrn_tid_i = '0;
    mem_rtrn_data_i = '0;
    mem_ack_i = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_sweep(1'b0);
    check("cache_en_o", cache_en_o, 0);
    // enabling the cache goes through a sweep
    @(posedge clk_i);
    enable_i <= 1'b1;
    check_sweep(1'b0);
    check("cache_en_o", cache_en_o, 1);
    // two reads at once, port 0 first
    run_batch(3'b011, 1'b0, 1'b0);
    wait_quiet();
    // store to the line of the read in flight
    run_batch(3'b101, 1'b1, 1'b0);
    wait_quiet();
    for (int b = 0; b < NumBatches - 2; b++) begin
      rand_bits(4, r);
      run_batch(r[2:0] == 0 ? 3'b001 : r[2:0], r[3], b % 4 == 0);
      wait_quiet();
    end
    // flush waits for the stores and the write buffer
    @(posedge clk_i);
    flush_i <= 1'b1;
    wbuffer_empty_i <= 1'b0;
    run_batch(3'b100, 1'b0, 1'b0);
    wait_quiet();
    repeat (3) @(negedge clk_i);
    @(posedge clk_i);
    wbuffer_empty_i <= 1'b1;
    check_sweep(1'b1);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: dcache_missunit.f
+incdir+source
source/missunit_pkg.sv
source/miss_port_arbiter.sv
source/refill_way_select.sv
source/miss_ctrl_fsm.sv
source/miss_rtrn_decode.sv
source/dcache_missunit.sv
tests/tb_dcache_missunit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the miss handler testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_dcache_missunit

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module "${TOP}" -f dcache_missunit.f -o "V${TOP}"; then
  echo "build failed"
  exit 1
fi

if ! "./obj_dir/V${TOP}" > "${LOG}" 2>&1; then
  cat "${LOG}"
  echo "simulation returned a failing status"
  exit 1
fi

cat "${LOG}"

if grep -qx "sim passed" "${LOG}"; then
  exit 0
else
  echo "pass message not found in ${LOG}"
  exit 1
fi
